// File: flist.f
hw/rv_isa_pkg.sv
hw/core_cfg_pkg.sv
hw/exec_bus_if.sv
hw/fetch_decode.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/rv_core.sv
testbench/core_checker.sv
testbench/tb_rv_core.sv

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
();

  localparam int CLK_PERIOD    = 40;
  localparam int DRIVE_DELAY   = 2;
  localparam int RESET_CYCLES  = 5;
  localparam int RANDOM_COUNT  = 200;
  localparam int WAIT_CYCLES   = 2000;
  localparam int IMEM_DEPTH    = 1 << IMEM_ADDR_W;

  logic       clk;
  logic       rst;
  imem_addr_t imem_addr;
  instr_t     imem_data;
  logic       wb_valid;
  reg_addr_t  wb_rd;
  word_t      wb_data;

  instr_t      imem [IMEM_DEPTH];
  int          prog_len;
  string       test_name [$];
  int          test_end  [$];
  logic [31:0] rng;

  logic chk_done;
  int   chk_errors;
  int   chk_compared;
  int   chk_addr;

  int fail_tests;
  int errs_before;
  bit reached;
  bit timed_out;

  rv_core i_rv_core (
    .clk_i       (clk      ),
    .rst_i       (rst      ),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .wb_valid_o  (wb_valid ),
    .wb_rd_o     (wb_rd    ),
    .wb_data_o   (wb_data  )
  );

  core_checker i_core_checker (
    .clk_i       (clk         ),
    .rst_i       (rst         ),
    .imem_addr_i (imem_addr   ),
    .imem_data_i (imem_data   ),
    .wb_valid_i  (wb_valid    ),
    .wb_rd_i     (wb_rd       ),
    .wb_data_i   (wb_data     ),
    .prog_len_i  (prog_len    ),
    .done_o      (chk_done    ),
    .err_count_o (chk_errors  ),
    .cmp_count_o (chk_compared),
    .cmp_addr_o  (chk_addr    )
  );

  // Instruction memory answers in the same cycle
  assign imem_data = imem[imem_addr];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------
  // Instruction encoding and program loading
  // --------------------------------------------------------------------
  function automatic instr_t r_type(input logic alt, input funct3_t f3,
                                    input int rd, input int rs1, input int rs2);
    return {1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
  endfunction

  function automatic instr_t i_type(input funct3_t f3, input int rd, input int rs1,
                                    input int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), OPC_OP_IMM};
  endfunction

  function automatic instr_t u_type(input int rd, input logic [19:0] imm);
    return {imm, 5'(rd), OPC_LUI};
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // r picks the group and registers and s gives immediates
  function automatic instr_t random_instr(input logic [31:0] r, input logic [31:0] s);
    funct3_t f3;
    logic    alt;
    opcode_t opc;
    f3  = r[14:12];
    alt = r[30] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA);
    case (r[2:0])
      3'd0, 3'd1, 3'd2: return r_type(alt, f3, r[10:7], r[19:16], r[23:20]);
      3'd3, 3'd4, 3'd5: begin
        if (f3 == F3_SLL) begin
          return i_type(f3, r[10:7], r[19:16], {7'b0, s[4:0]});
        end else if (f3 == F3_SRL_SRA) begin
          return i_type(f3, r[10:7], r[19:16], {1'b0, r[30], 5'b0, s[4:0]});
        end
        return i_type(f3, r[10:7], r[19:16], s[11:0]);
      end
      3'd6: return u_type(r[10:7], s[31:12]);
      default: begin
        // Load, store, branch and JAL are not executed
        case (r[4:3])
          2'd0:    opc = 7'b0000011;
          2'd1:    opc = 7'b0100011;
          2'd2:    opc = 7'b1100011;
          default: opc = 7'b1101111;
        endcase
        return {s[31:7], opc};
      end
    endcase
  endfunction

  task automatic load_instr(input instr_t instr);
    imem[prog_len] = instr;
    prog_len++;
  endtask

  task automatic close_section(input string name);
    test_name.push_back(name);
    test_end.push_back(prog_len - 1);
  endtask

  task automatic build_program();
    logic [31:0] r;
    foreach (imem[i]) begin
      imem[i] = NOP_INSTR;
    end
    prog_len = 0;
    // Operands with sign and shift edge cases
    load_instr(u_type(1, 20'h80000));
    load_instr(i_type(F3_ADD_SUB, 2, 0, -1));
    load_instr(i_type(F3_ADD_SUB, 3, 0, 31));
    load_instr(u_type(4, 20'h80000));
    load_instr(i_type(F3_ADD_SUB, 4, 4, -1));
    load_instr(i_type(F3_ADD_SUB, 5, 0, 1));
    close_section("reset and fetch order");
    load_instr(r_type(1'b0, F3_ADD_SUB, 10, 1, 2));
    load_instr(r_type(1'b1, F3_ADD_SUB, 11, 1, 5));
    load_instr(r_type(1'b0, F3_SLL, 12, 5, 3));
    load_instr(r_type(1'b0, F3_SLT, 13, 1, 4));
    load_instr(r_type(1'b0, F3_SLTU, 14, 1, 4));
    load_instr(r_type(1'b0, F3_XOR, 15, 2, 4));
    load_instr(r_type(1'b0, F3_SRL_SRA, 16, 1, 3));
    load_instr(r_type(1'b1, F3_SRL_SRA, 17, 1, 3));
    load_instr(r_type(1'b0, F3_OR, 18, 1, 4));
    load_instr(r_type(1'b0, F3_AND, 19, 2, 4));
    load_instr(r_type(1'b0, F3_SLL, 20, 5, 2));
    close_section("register ALU ops");
    load_instr(i_type(F3_ADD_SUB, 6, 1, -2048));
    load_instr(i_type(F3_SLT, 7, 2, -1));
    load_instr(i_type(F3_SLT, 7, 2, 0));
    load_instr(i_type(F3_SLTU, 8, 5, -1));
    load_instr(i_type(F3_XOR, 9, 2, 12'h555));
    load_instr(i_type(F3_OR, 21, 1, -16));
    load_instr(i_type(F3_AND, 22, 2, 12'h7f0));
    load_instr(i_type(F3_SLL, 23, 5, 31));
    load_instr(i_type(F3_SLL, 24, 4, 0));
    load_instr(i_type(F3_SRL_SRA, 25, 1, 31));
    load_instr(i_type(F3_SRL_SRA, 26, 1, 12'h400 | 31));
    load_instr(i_type(F3_SRL_SRA, 27, 1, 12'h400));
    load_instr(u_type(28, 20'hfffff));
    load_instr(u_type(29, 20'h12345));
    close_section("immediate ops and LUI");
    // Distance one and then distance two with a spacer
    load_instr(i_type(F3_ADD_SUB, 1, 0, 5));
    load_instr(r_type(1'b0, F3_ADD_SUB, 2, 1, 1));
    load_instr(r_type(1'b1, F3_ADD_SUB, 3, 0, 2));
    load_instr(i_type(F3_ADD_SUB, 4, 0, 7));
    load_instr(i_type(F3_ADD_SUB, 5, 0, 3));
    load_instr(r_type(1'b0, F3_ADD_SUB, 6, 4, 0));
    load_instr(r_type(1'b1, F3_ADD_SUB, 7, 0, 5));
    load_instr(i_type(F3_ADD_SUB, 10, 10, 1));
    load_instr(i_type(F3_ADD_SUB, 10, 10, 1));
    load_instr(i_type(F3_ADD_SUB, 10, 10, 1));
    load_instr(r_type(1'b0, F3_XOR, 11, 10, 10));
    close_section("forwarding and bypass");
    load_instr(i_type(F3_ADD_SUB, 0, 0, 123));
    load_instr(r_type(1'b0, F3_ADD_SUB, 11, 0, 0));
    load_instr(r_type(1'b0, F3_ADD_SUB, 0, 1, 1));
    load_instr(u_type(0, 20'habcde));
    load_instr(32'h0000_2083);
    load_instr(32'h0000_00ef);
    load_instr(32'h0000_0097);
    load_instr(32'h0000_0073);
    load_instr(r_type(1'b0, F3_OR, 12, 0, 0));
    load_instr(i_type(F3_ADD_SUB, 13, 0, 0));
    close_section("x0 and unsupported opcodes");
    rng = 32'h9df;
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      rng = xorshift32(rng);
      r   = rng;
      rng = xorshift32(rng);
      load_instr(random_instr(r, rng));
    end
    close_section("random program");
  endtask

  // --------------------------------------------------------------------
  // Waits bounded in cycles
  // --------------------------------------------------------------------
  task automatic wait_for_word(input int addr, output bit ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < WAIT_CYCLES) begin
      @(posedge clk);
      cycles++;
      ok = (chk_addr >= addr);
    end
    if (!ok) begin
      $display("Timeout: the checker did not reach word %0d within %0d cycles",
               addr, WAIT_CYCLES);
    end
  endtask

  task automatic wait_for_done(output bit ok);
    int cycles;
    ok     = 1'b0;
    cycles = 0;
    while (!ok && cycles < WAIT_CYCLES) begin
      @(posedge clk);
      cycles++;
      ok = chk_done;
    end
    if (!ok) begin
      $display("Timeout: the checker never signalled the end of the program");
    end
  endtask

  initial begin
    rst         = 1'b1;
    fail_tests  = 0;
    errs_before = 0;
    timed_out   = 1'b0;
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY rst = 1'b0;

    foreach (test_end[t]) begin
      if (!timed_out) begin
        wait_for_word(test_end[t], reached);
        timed_out = !reached;
        if (!reached || chk_errors != errs_before) begin
          fail_tests++;
        end
        $display("Test %s: %s, %0d errors", test_name[t],
                 (reached && chk_errors == errs_before) ? "passed" : "failed",
                 chk_errors - errs_before);
        errs_before = chk_errors;
      end
    end
    if (!timed_out) begin
      wait_for_done(reached);
      timed_out = !reached;
    end

    $display("Summary: %0d tests, %0d failed, %0d writes compared, %0d errors",
             test_end.size(), fail_tests, chk_compared, chk_errors);
    if (fail_tests == 0 && !timed_out && chk_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  imem_addr_t imem_addr_i,
  input  instr_t     imem_data_i,
  input  logic       wb_valid_i,
  input  reg_addr_t  wb_rd_i,
  input  word_t      wb_data_i,
  input  int         prog_len_i,
  output logic       done_o,
  output int         err_count_o,
  output int         cmp_count_o,
  output int         cmp_addr_o
);

  typedef word_t reg_array_t [32];

  // Architectural state as the ISA defines it
  reg_array_t ref_regs;

  // Expected write-backs, oldest first, one entry per fetch
  logic      exp_wr_q   [$];
  reg_addr_t exp_rd_q   [$];
  word_t     exp_val_q  [$];
  int        exp_addr_q [$];

  int   next_fetch = 0;
  int   err_count  = 0;
  int   cmp_count  = 0;
  int   cmp_addr   = -1;
  logic done       = 1'b0;

  assign done_o      = done;
  assign err_count_o = err_count;
  assign cmp_count_o = cmp_count;
  assign cmp_addr_o  = cmp_addr;

  // --------------------------------------------------------------------
  // Reference model of the kept RV32I subset
  // --------------------------------------------------------------------
  function automatic logic expected_write(input instr_t instr, input reg_array_t regs,
                                          output reg_addr_t rd, output word_t value);
    opcode_t opc;
    logic    is_imm;
    word_t   a;
    word_t   b;
    logic [4:0] sh;
    opc   = instr[6:0];
    rd    = instr[11:7];
    value = '0;
    if (opc == OPC_LUI) begin
      value = {instr[31:12], 12'h000};
      return rd != 5'd0;
    end
    if (opc != OPC_OP && opc != OPC_OP_IMM) begin
      return 1'b0;
    end
    is_imm = (opc == OPC_OP_IMM);
    a      = regs[instr[19:15]];
    b      = is_imm ? {{20{instr[31]}}, instr[31:20]} : regs[instr[24:20]];
    sh     = b[4:0];
    case (instr[14:12])
      F3_ADD_SUB: value = (!is_imm && instr[30]) ? a - b : a + b;
      F3_SLL:     value = a << sh;
      // Signs differ: the negative one is smaller
      F3_SLT:     value = {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
      F3_SLTU:    value = {31'd0, a < b};
      F3_XOR:     value = a ^ b;
      F3_SRL_SRA: begin
        value = a >> sh;
        if (instr[30] && a[31]) begin
          value = value | ~(32'hffff_ffff >> sh);
        end
      end
      F3_OR:      value = a | b;
      default:    value = a & b;
    endcase
    return rd != 5'd0;
  endfunction

  // --------------------------------------------------------------------
  // Comparison, sampled mid-cycle where the DUT outputs are settled
  // --------------------------------------------------------------------
  task automatic compare_oldest();
    logic      wr;
    reg_addr_t rd;
    word_t     val;
    int        addr;
    wr   = 1'b0;
    addr = -1;
    // Entries younger than three cycles are still in flight
    if (exp_wr_q.size() >= 3) begin
      wr   = exp_wr_q.pop_front();
      rd   = exp_rd_q.pop_front();
      val  = exp_val_q.pop_front();
      addr = exp_addr_q.pop_front();
    end
    if (wr) begin
      cmp_count++;
      if (wb_valid_i !== 1'b1) begin
        $display("Missing write-back to x%0d for the instruction at word %0d, time %0t",
                 rd, addr, $time);
        err_count++;
      end else if (wb_rd_i !== rd || wb_data_i !== val) begin
        $display("FAIL %0t: word %0d wrote x%0d = %h, expected x%0d = %h",
                 $time, addr, wb_rd_i, wb_data_i, rd, val);
        err_count++;
      end
    end else if (wb_valid_i !== 1'b0) begin
      $display("Unexpected write-back to x%0d at time %0t", wb_rd_i, $time);
      err_count++;
    end
    if (addr >= 0) begin
      cmp_addr = addr;
      if (addr == prog_len_i - 1) begin
        done = 1'b1;
      end
    end
  endtask

  task automatic record_fetch();
    logic      wr;
    reg_addr_t rd;
    word_t     val;
    if (imem_addr_i !== imem_addr_t'(next_fetch)) begin
      $display("FAIL %0t: fetch from word %0d, expected word %0d",
               $time, imem_addr_i, next_fetch);
      err_count++;
    end
    next_fetch++;
    wr = expected_write(imem_data_i, ref_regs, rd, val);
    if (wr) begin
      ref_regs[rd] = val;
    end
    exp_wr_q.push_back(wr);
    exp_rd_q.push_back(rd);
    exp_val_q.push_back(val);
    exp_addr_q.push_back(int'(imem_addr_i));
  endtask

  always @(negedge clk_i) begin
    if (rst_i) begin
      if (wb_valid_i !== 1'b0) begin
        $display("Write-back valid was not low during reset at time %0t", $time);
        err_count++;
      end
      foreach (ref_regs[i]) begin
        ref_regs[i] = '0;
      end
      exp_wr_q.delete();
      exp_rd_q.delete();
      exp_val_q.delete();
      exp_addr_q.delete();
      next_fetch = 0;
      cmp_addr   = -1;
      done       = 1'b0;
    end else begin
      compare_oldest();
      record_fetch();
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  output imem_addr_t imem_addr_o,
  input  instr_t     imem_data_i,
  output logic       wb_valid_o,
  output reg_addr_t  wb_rd_o,
  output word_t      wb_data_o
);

  // Register file read ports, driven from ID
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;

  // ID/EX stage
  exec_bus_if ex_bus ();

  // --------------------------------------------------------------------
  // Pipeline units
  // --------------------------------------------------------------------
  fetch_decode i_fetch_decode (
    .clk_i       (clk_i      ),
    .rst_i       (rst_i      ),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .rs1_addr_o  (rs1_addr   ),
    .rs2_addr_o  (rs2_addr   ),
    .rs1_data_i  (rs1_data   ),
    .rs2_data_i  (rs2_data   ),
    .ex_bus      (ex_bus     )
  );

  // Write port is the write-back bus
  reg_file i_reg_file (
    .clk_i      (clk_i     ),
    .rst_i      (rst_i     ),
    .rs1_addr_i (rs1_addr  ),
    .rs2_addr_i (rs2_addr  ),
    .rs1_data_o (rs1_data  ),
    .rs2_data_o (rs2_data  ),
    .wr_en_i    (wb_valid_o),
    .wr_addr_i  (wb_rd_o   ),
    .wr_data_i  (wb_data_o )
  );

  execute_unit i_execute_unit (
    .clk_i      (clk_i     ),
    .rst_i      (rst_i     ),
    .ex_bus     (ex_bus    ),
    .wb_valid_o (wb_valid_o),
    .wb_rd_o    (wb_rd_o   ),
    .wb_data_o  (wb_data_o )
  );

endmodule

`default_nettype wire

// File: hw/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  exec_bus_if.consumer ex_bus,
  output logic         wb_valid_o,
  output reg_addr_t    wb_rd_o,
  output word_t        wb_data_o
);

  // EX/WB register
  logic      wb_valid_q;
  reg_addr_t wb_rd_q;
  word_t     wb_data_q;

  logic      fwd_a;
  logic      fwd_b;
  word_t     op_a;
  word_t     rs2_val;
  word_t     op_b;
  shamt_t    shamt;
  word_t     alu_res;

  // --------------------------------------------------------------------
  // Operand selection
  // --------------------------------------------------------------------

  // The older instruction in WB has not reached the register file yet
  assign fwd_a = wb_valid_q && (wb_rd_q == ex_bus.rs1);
  assign fwd_b = wb_valid_q && (wb_rd_q == ex_bus.rs2);

  assign op_a    = fwd_a ? wb_data_q : ex_bus.rs1_data;
  assign rs2_val = fwd_b ? wb_data_q : ex_bus.rs2_data;
  assign op_b    = ex_bus.use_imm ? ex_bus.imm : rs2_val;

  // Low five bits, for both register and immediate shifts
  assign shamt = op_b[4:0];

  // --------------------------------------------------------------------
  // ALU
  // --------------------------------------------------------------------
  always_comb begin
    case (ex_bus.alu_op)
      ALU_ADD: begin
        alu_res = op_a + op_b;
      end
      ALU_SUB: begin
        alu_res = op_a - op_b;
      end
      ALU_SLL: begin
        alu_res = op_a << shamt;
      end
      ALU_SLT: begin
        alu_res = word_t'($signed(op_a) < $signed(op_b));
      end
      ALU_SLTU: begin
        alu_res = word_t'(op_a < op_b);
      end
      ALU_XOR: begin
        alu_res = op_a ^ op_b;
      end
      ALU_SRL: begin
        alu_res = op_a >> shamt;
      end
      // Arithmetic shift keeps the sign
      ALU_SRA: begin
        alu_res = word_t'($signed(op_a) >>> shamt);
      end
      ALU_OR: begin
        alu_res = op_a | op_b;
      end
      ALU_AND: begin
        alu_res = op_a & op_b;
      end
      default: begin
        alu_res = '0;
      end
    endcase
  end

  // --------------------------------------------------------------------
  // EX/WB register
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= ex_bus.valid && ex_bus.reg_write;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_q   <= ex_bus.rd;
    wb_data_q <= alu_res;
  end

  // Same signals as the register file write port
  assign wb_valid_o = wb_valid_q;
  assign wb_rd_o    = wb_rd_q;
  assign wb_data_o  = wb_data_q;

  // Valid bits travel from decode without gaps
  wb_valid_known_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !$isunknown(wb_valid_o));

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import rv_isa_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  output word_t     rs1_data_o,
  output word_t     rs2_data_o,
  input  logic      wr_en_i,
  input  reg_addr_t wr_addr_i,
  input  word_t     wr_data_i
);

  // x0 has no storage
  word_t regs_q [1:31];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  // A write in the same cycle wins over the stored value
  function automatic word_t read_port(input reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end
    if (wr_en_i && (wr_addr_i == addr)) begin
      return wr_data_i;
    end
    return regs_q[addr];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_addr_i);
    rs2_data_o = read_port(rs2_addr_i);
  end

  // Decode drops x0 writes before they reach write-back
  no_x0_write_a: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_en_i |-> wr_addr_i != '0);

endmodule

`default_nettype wire

// File: hw/fetch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_decode
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  output imem_addr_t  imem_addr_o,
  input  instr_t      imem_data_i,
  output reg_addr_t   rs1_addr_o,
  output reg_addr_t   rs2_addr_o,
  input  word_t       rs1_data_i,
  input  word_t       rs2_data_i,
  exec_bus_if.producer ex_bus
);

  word_t     pc_q;
  logic      id_valid_q;
  instr_t    id_instr_q;

  opcode_t   opcode;
  funct3_t   funct3;
  logic      alt_bit;
  reg_addr_t rd;
  reg_addr_t rs1_sel;
  word_t     imm_i;
  word_t     imm_u;
  word_t     imm_sel;
  alu_op_e   alu_op;
  logic      use_imm;
  logic      supported;

  // --------------------------------------------------------------------
  // IF stage
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_q + PC_STEP;
    end
  end

  assign imem_addr_o = pc_q[PC_WORD_LSB +: IMEM_ADDR_W];

  // IF/ID valid bit rises with the first fetch after reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_valid_q <= 1'b0;
    end else begin
      id_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    id_instr_q <= imem_data_i;
  end

  // --------------------------------------------------------------------
  // ID stage
  // --------------------------------------------------------------------
  assign opcode  = id_instr_q[OPCODE_LSB +: $bits(opcode_t)];
  assign funct3  = id_instr_q[FUNCT3_LSB +: $bits(funct3_t)];
  assign alt_bit = id_instr_q[FUNCT7_ALT_BIT];
  assign rd      = id_instr_q[RD_LSB +: $bits(reg_addr_t)];
  assign imm_i   = {{20{id_instr_q[31]}}, id_instr_q[31:I_IMM_LSB]};
  assign imm_u   = {id_instr_q[31:U_IMM_LSB], 12'b0};

  // No SUBI exists since bit 30 belongs to the I-immediate
  function automatic alu_op_e decode_alu(input funct3_t f3, input logic alt, input logic is_imm);
    case (f3)
      F3_ADD_SUB: return (alt && !is_imm) ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  always_comb begin
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    supported = 1'b0;
    rs1_sel   = id_instr_q[RS1_LSB +: $bits(reg_addr_t)];
    imm_sel   = imm_i;
    case (opcode)
      OPC_OP: begin
        supported = 1'b1;
        alu_op    = decode_alu(funct3, alt_bit, 1'b0);
      end
      OPC_OP_IMM: begin
        supported = 1'b1;
        use_imm   = 1'b1;
        alu_op    = decode_alu(funct3, alt_bit, 1'b1);
      end
      // x0 + U-immediate
      OPC_LUI: begin
        supported = 1'b1;
        use_imm   = 1'b1;
        rs1_sel   = '0;
        imm_sel   = imm_u;
      end
      default: begin
        supported = 1'b0;
      end
    endcase
  end

  assign rs1_addr_o = rs1_sel;
  assign rs2_addr_o = id_instr_q[RS2_LSB +: $bits(reg_addr_t)];

  // --------------------------------------------------------------------
  // ID/EX register
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_bus.valid <= 1'b0;
    end else begin
      ex_bus.valid <= id_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_bus.alu_op    <= alu_op;
    ex_bus.rd        <= rd;
    ex_bus.rs1       <= rs1_sel;
    ex_bus.rs2       <= rs2_addr_o;
    ex_bus.rs1_data  <= rs1_data_i;
    ex_bus.rs2_data  <= rs2_data_i;
    ex_bus.imm       <= imm_sel;
    ex_bus.use_imm   <= use_imm;
    // Unsupported opcodes and x0 targets retire without a write
    ex_bus.reg_write <= supported && (rd != '0);
  end

  // Fetch never stalls once out of reset, one word per clock
  pc_step_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) |-> imem_addr_o == imem_addr_t'($past(imem_addr_o) + 1'b1));

endmodule

`default_nettype wire

// File: hw/exec_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// ID/EX pipeline register, written by decode and read by execute
interface exec_bus_if
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
();

  logic      valid;
  alu_op_e   alu_op;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     imm;
  logic      use_imm;
  logic      reg_write;

  modport producer (
    output valid, alu_op, rd, rs1, rs2, rs1_data, rs2_data, imm, use_imm, reg_write
  );

  modport consumer (
    input valid, alu_op, rd, rs1, rs2, rs1_data, rs2_data, imm, use_imm, reg_write
  );

endinterface

`default_nettype wire

// File: hw/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

  // --------------------------------------------------------------------
  // Instruction fetch
  // --------------------------------------------------------------------

  // Word address into instruction memory, byte address bits 15..2
  localparam int unsigned IMEM_ADDR_W = 14;

  typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  // Bytes per instruction
  localparam int unsigned PC_STEP = 4;

  // Lowest PC bit that selects a word
  localparam int unsigned PC_WORD_LSB = $clog2(PC_STEP);

  // --------------------------------------------------------------------
  // Execute stage
  // --------------------------------------------------------------------

  // LUI reuses ALU_ADD with a zero first operand
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

endpackage

`default_nettype wire

// File: hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // Widths with an architectural meaning
  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [4:0]  shamt_t;

  // --------------------------------------------------------------------
  // Major opcodes of the supported groups
  // --------------------------------------------------------------------
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;

  // ALU funct3 encodings, shared by OP and OP-IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // --------------------------------------------------------------------
  // Field positions inside an instruction word
  // --------------------------------------------------------------------
  localparam int unsigned OPCODE_LSB     = 0;
  localparam int unsigned RD_LSB         = 7;
  localparam int unsigned FUNCT3_LSB     = 12;
  localparam int unsigned RS1_LSB        = 15;
  localparam int unsigned RS2_LSB        = 20;
  localparam int unsigned FUNCT7_ALT_BIT = 30;
  localparam int unsigned I_IMM_LSB      = 20;
  localparam int unsigned U_IMM_LSB      = 12;

  // ADDI x0, x0, 0
  localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire
